//--- rtl/outpkt_pkg.sv
package outpkt_pkg;

	// protocol version, sent in the low byte of header word 0
	localparam logic [7:0] PKT_VERSION = 8'h02;
	// fixed header word 1, an arbitrary value that helps the checksum
	localparam logic [15:0] HDR_RESERVED = 16'h35b9;
	localparam int HDR_WORDS = 5;

	// result buffer layout, one 16-bit word per address
	//   0     word id
	//   1     unused
	//   2..3  generator id, low word first
	//   4..11 result
	localparam int BUF_DEPTH = 16;
	localparam int BUF_AW = 4;
	localparam int RESULT_WORDS = 8;
	localparam logic [BUF_AW-1:0] ADDR_WORD_ID = 4'd0;
	localparam logic [BUF_AW-1:0] ADDR_GEN_ID = 4'd2;
	localparam logic [BUF_AW-1:0] ADDR_RESULT = 4'd4;

	// formatter word counter, wide enough for header and result runs
	localparam int FMT_CNT_W = 3;

	// word credits granted by the host link after reset
	localparam int OUT_CREDITS = 4;
	localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);

	typedef enum logic [1:0] {
		PKT_DONE       = 2'd0,
		PKT_RESULT     = 2'd1,
		PKT_CMP_RESULT = 2'd2
	} pkt_type_t;

	// type ids as seen by the host
	localparam logic [7:0] TYPE_ID_DONE       = 8'hd2;
	localparam logic [7:0] TYPE_ID_RESULT     = 8'hd3;
	localparam logic [7:0] TYPE_ID_CMP_RESULT = 8'hd4;

	// body length in bytes, header and checksum excluded
	localparam logic [7:0] RESULT_BYTES   = 8'(2 * RESULT_WORDS);
	localparam logic [7:0] LEN_DONE       = 8'd4;
	localparam logic [7:0] LEN_RESULT     = 8'd6 + RESULT_BYTES;
	localparam logic [7:0] LEN_CMP_RESULT = 8'd8 + RESULT_BYTES;

	typedef struct packed {
		pkt_type_t   pkt_type;
		logic [15:0] pkt_id;
		logic [7:0]  hash_num;
		logic [31:0] num_processed;
	} outpkt_req_t;

	typedef struct packed {
		logic [7:0] type_id;
		logic [7:0] len_bytes;
		logic       has_buffer;
		logic       has_hash_num;
	} pkt_info_t;

	typedef struct packed {
		logic [15:0] data;
		logic        first;
		logic        last;
	} stream_word_t;

	typedef struct packed {
		logic [15:0] data;
		logic        last;
	} host_word_t;

endpackage

//--- rtl/result_buffer.sv
`timescale 1ns/100ps

module result_buffer
	import outpkt_pkg::*;
(
	input  logic              CLK,

	// write side, filled by the hash core
	input  logic              buf_we,
	input  logic [BUF_AW-1:0] buf_addr,
	input  logic [15:0]       buf_wdata,

	// read side, one cycle from address to data
	input  logic [BUF_AW-1:0] rd_addr,
	output logic [15:0]       rd_data
);

	logic [15:0] mem [BUF_DEPTH];

	always_ff @(posedge CLK) begin
		if (buf_we) begin
			mem[buf_addr] <= buf_wdata;
		end
	end

	// registered read, maps onto block or distributed ram with output register
	always_ff @(posedge CLK) begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- rtl/outpkt_type_decode.sv
`timescale 1ns/100ps

module outpkt_type_decode
	import outpkt_pkg::*;
(
	input  pkt_type_t pkt_type,
	output pkt_info_t info
);

	always_comb begin
		info = '0;
		case (pkt_type)
			PKT_DONE: begin
				info.type_id      = TYPE_ID_DONE;
				info.len_bytes    = LEN_DONE;
				info.has_buffer   = 1'b0;
				info.has_hash_num = 1'b0;
			end
			PKT_RESULT: begin
				info.type_id      = TYPE_ID_RESULT;
				info.len_bytes    = LEN_RESULT;
				info.has_buffer   = 1'b1;
				info.has_hash_num = 1'b0;
			end
			PKT_CMP_RESULT: begin
				info.type_id      = TYPE_ID_CMP_RESULT;
				info.len_bytes    = LEN_CMP_RESULT;
				info.has_buffer   = 1'b1;
				info.has_hash_num = 1'b1;
			end
			// code 3 is not a packet type, leave everything zero
			default: begin
				info = '0;
			end
		endcase
	end

endmodule

//--- rtl/outpkt_formatter.sv
`timescale 1ns/100ps

module outpkt_formatter
	import outpkt_pkg::*;
(
	input  logic              CLK,
	input  logic              rst_n,

	// request from the hash core
	input  logic              req_valid,
	input  outpkt_req_t       req,
	input  pkt_info_t         info,
	output logic              req_done,

	// result buffer read port
	output logic [BUF_AW-1:0] rd_addr,
	input  logic [15:0]       rd_data,

	// word stream to the checksum stage
	output logic              fmt_valid,
	output stream_word_t      fmt_word,
	input  logic              fmt_ready
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_HEADER,
		S_NUM_PROC,
		S_WORD_ID,
		S_GEN_ID,
		S_HASH_NUM,
		S_RESULT
	} state_t;

	state_t                 state;
	state_t                 nxt_state;
	logic [FMT_CNT_W-1:0]   cnt;
	logic [FMT_CNT_W-1:0]   nxt_cnt;
	logic [BUF_AW-1:0]      addr;
	logic [BUF_AW-1:0]      nxt_addr;
	logic                   adv;
	logic                   ld;
	stream_word_t           nxt_word;
	logic [15:0]            hdr_data;

	// output register is free or drains this cycle
	assign adv = !fmt_valid || fmt_ready;

	always_comb begin
		case (cnt)
			FMT_CNT_W'(0): hdr_data = {info.type_id, PKT_VERSION};
			FMT_CNT_W'(1): hdr_data = HDR_RESERVED;
			FMT_CNT_W'(2): hdr_data = {8'h00, info.len_bytes};
			FMT_CNT_W'(4): hdr_data = req.pkt_id;
			default:       hdr_data = 16'h0000;
		endcase
	end

	always_comb begin
		nxt_state = state;
		nxt_cnt   = cnt;
		nxt_addr  = addr;
		ld        = 1'b0;
		nxt_word  = '0;
		if (adv) begin
			case (state)
				S_IDLE: begin
					// wait until the previous request has been retired
					if (req_valid && !req_done && !fmt_valid) begin
						nxt_state = S_HEADER;
						nxt_cnt   = '0;
						nxt_addr  = ADDR_WORD_ID;
					end
				end
				S_HEADER: begin
					ld             = 1'b1;
					nxt_word.data  = hdr_data;
					nxt_word.first = (cnt == FMT_CNT_W'(0));
					if (cnt == FMT_CNT_W'(HDR_WORDS - 1)) begin
						nxt_cnt   = '0;
						nxt_state = info.has_buffer ? S_WORD_ID : S_NUM_PROC;
					end else begin
						nxt_cnt = cnt + 1'b1;
					end
				end
				S_NUM_PROC: begin
					ld = 1'b1;
					if (cnt == FMT_CNT_W'(0)) begin
						nxt_word.data = req.num_processed[15:0];
						nxt_cnt       = cnt + 1'b1;
					end else begin
						nxt_word.data = req.num_processed[31:16];
						nxt_word.last = 1'b1;
						nxt_cnt       = '0;
						nxt_state     = S_IDLE;
					end
				end
				S_WORD_ID: begin
					ld            = 1'b1;
					nxt_word.data = rd_data;
					nxt_addr      = ADDR_GEN_ID;
					nxt_state     = S_GEN_ID;
				end
				S_GEN_ID: begin
					ld            = 1'b1;
					nxt_word.data = rd_data;
					if (cnt == FMT_CNT_W'(0)) begin
						nxt_addr = addr + 1'b1;
						nxt_cnt  = cnt + 1'b1;
					end else begin
						nxt_addr  = ADDR_RESULT;
						nxt_cnt   = '0;
						nxt_state = info.has_hash_num ? S_HASH_NUM : S_RESULT;
					end
				end
				S_HASH_NUM: begin
					// address already sits on the first result word
					ld            = 1'b1;
					nxt_word.data = {8'h00, req.hash_num};
					nxt_state     = S_RESULT;
				end
				S_RESULT: begin
					ld            = 1'b1;
					nxt_word.data = rd_data;
					nxt_addr      = addr + 1'b1;
					if (cnt == FMT_CNT_W'(RESULT_WORDS - 1)) begin
						nxt_word.last = 1'b1;
						nxt_cnt       = '0;
						nxt_state     = S_IDLE;
					end else begin
						nxt_cnt = cnt + 1'b1;
					end
				end
				default: begin
					nxt_state = S_IDLE;
				end
			endcase
		end
	end

	// the buffer registers this address, so its data lines up with the next word
	assign rd_addr = nxt_addr;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			cnt       <= '0;
			addr      <= ADDR_WORD_ID;
			fmt_valid <= 1'b0;
			req_done  <= 1'b0;
		end else begin
			state    <= nxt_state;
			cnt      <= nxt_cnt;
			addr     <= nxt_addr;
			req_done <= fmt_valid && fmt_ready && fmt_word.last;
			if (adv) begin
				fmt_valid <= ld;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (adv && ld) begin
			fmt_word <= nxt_word;
		end
	end

endmodule

//--- rtl/outpkt_checksum.sv
`timescale 1ns/100ps

module outpkt_checksum
	import outpkt_pkg::*;
(
	input  logic         CLK,
	input  logic         rst_n,

	// word stream from the formatter
	input  logic         fmt_valid,
	input  stream_word_t fmt_word,
	output logic         fmt_ready,

	// host link, credit based
	input  logic         credit_return,
	output logic         out_valid,
	output host_word_t   out_word
);

	typedef enum logic [1:0] {
		PH_DATA,
		PH_CSUM_LO,
		PH_CSUM_HI
	} phase_t;

	phase_t              phase;
	logic [CREDIT_W-1:0] credit_cnt;
	logic                obuf_full;
	host_word_t          obuf;
	logic [31:0]         sum;
	logic                take;
	logic                wr_data;
	logic                wr_lo;
	logic                wr_hi;

	// a word leaves only while a credit is available
	assign out_valid = obuf_full && (credit_cnt != '0);
	assign out_word  = obuf;

	// output register can be loaded this cycle
	assign take      = !obuf_full || out_valid;
	assign fmt_ready = take && (phase == PH_DATA);

	assign wr_data = fmt_valid && fmt_ready;
	assign wr_lo   = take && (phase == PH_CSUM_LO);
	assign wr_hi   = take && (phase == PH_CSUM_HI);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			phase      <= PH_DATA;
			obuf_full  <= 1'b0;
			credit_cnt <= CREDIT_W'(OUT_CREDITS);
		end else begin
			credit_cnt <= credit_cnt - CREDIT_W'(out_valid) + CREDIT_W'(credit_return);
			if (wr_data || wr_lo || wr_hi) begin
				obuf_full <= 1'b1;
			end else if (out_valid) begin
				obuf_full <= 1'b0;
			end
			if (wr_data && fmt_word.last) begin
				phase <= PH_CSUM_LO;
			end else if (wr_lo) begin
				phase <= PH_CSUM_HI;
			end else if (wr_hi) begin
				phase <= PH_DATA;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_data) begin
			obuf.data <= fmt_word.data;
			obuf.last <= 1'b0;
			// a first word starts a new packet sum
			if (fmt_word.first) begin
				sum <= {16'h0000, fmt_word.data};
			end else begin
				sum <= sum + {16'h0000, fmt_word.data};
			end
		end else if (wr_lo) begin
			obuf.data <= ~sum[15:0];
			obuf.last <= 1'b0;
		end else if (wr_hi) begin
			obuf.data <= ~sum[31:16];
			obuf.last <= 1'b1;
		end
	end

endmodule

//--- rtl/outpkt_top.sv
`timescale 1ns/100ps

module outpkt_top
	import outpkt_pkg::*;
(
	input  logic              CLK,
	input  logic              rst_n,

	// result buffer fill from the hash core
	input  logic              buf_we,
	input  logic [BUF_AW-1:0] buf_addr,
	input  logic [15:0]       buf_wdata,

	// packet request
	input  logic              req_valid,
	input  outpkt_req_t       req,
	output logic              req_done,

	// host link
	input  logic              credit_return,
	output logic              out_valid,
	output host_word_t        out_word
);

	logic [BUF_AW-1:0] rd_addr;
	logic [15:0]       rd_data;
	pkt_info_t         info;
	logic              fmt_valid;
	stream_word_t      fmt_word;
	logic              fmt_ready;

	result_buffer u_buffer (
		.CLK       (CLK),
		.buf_we    (buf_we),
		.buf_addr  (buf_addr),
		.buf_wdata (buf_wdata),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	outpkt_type_decode u_decode (
		.pkt_type (req.pkt_type),
		.info     (info)
	);

	outpkt_formatter u_formatter (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req       (req),
		.info      (info),
		.req_done  (req_done),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.fmt_valid (fmt_valid),
		.fmt_word  (fmt_word),
		.fmt_ready (fmt_ready)
	);

	outpkt_checksum u_checksum (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.fmt_valid     (fmt_valid),
		.fmt_word      (fmt_word),
		.fmt_ready     (fmt_ready),
		.credit_return (credit_return),
		.out_valid     (out_valid),
		.out_word      (out_word)
	);

endmodule

//--- tests/outpkt_sva.sv
`timescale 1ns/100ps

module outpkt_sva
	import outpkt_pkg::*;
(
	input logic                CLK,
	input logic                rst_n,
	input logic                out_valid,
	input logic                credit_return,
	input logic [CREDIT_W-1:0] credit_cnt,
	input logic                req_valid,
	input logic                req_done,
	input logic [1:0]          req_type
);

	// words on the link that the host has not credited back yet
	logic [CREDIT_W-1:0] in_flight;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			in_flight <= '0;
		end else begin
			in_flight <= in_flight + CREDIT_W'(out_valid) - CREDIT_W'(credit_return);
		end
	end

	// a word may only leave against a credit the host still grants
	a_spend_credit: assert property (@(posedge CLK) disable iff (!rst_n)
		out_valid |-> (in_flight < CREDIT_W'(OUT_CREDITS)))
		else $error("out_valid high with no credit left");

	a_credit_limit: assert property (@(posedge CLK) disable iff (!rst_n)
		credit_cnt <= CREDIT_W'(OUT_CREDITS))
		else $error("credit counter above the granted credits");

	a_done_pulse: assert property (@(posedge CLK) disable iff (!rst_n)
		req_done |=> !req_done)
		else $error("req_done held for more than one cycle");

	a_legal_type: assert property (@(posedge CLK) disable iff (!rst_n)
		req_valid |-> (req_type != 2'd3))
		else $error("request with illegal packet type code 3");

endmodule

// credit rules on the checksum stage
bind outpkt_checksum outpkt_sva u_credit_sva (
	.CLK           (CLK),
	.rst_n         (rst_n),
	.out_valid     (out_valid),
	.credit_return (credit_return),
	.credit_cnt    (credit_cnt),
	.req_valid     (1'b0),
	.req_done      (1'b0),
	.req_type      (2'b00)
);

// request rules at the top level
bind outpkt_top outpkt_sva u_req_sva (
	.CLK           (CLK),
	.rst_n         (rst_n),
	.out_valid     (1'b0),
	.credit_return (1'b0),
	.credit_cnt    ('0),
	.req_valid     (req_valid),
	.req_done      (req_done),
	.req_type      (req.pkt_type)
);

//--- tests/outpkt_tb.sv
`timescale 1ns/100ps

module outpkt_tb
	import outpkt_pkg::*;
();

	localparam int NUM_TESTS = 24;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 200 + 16;

	logic              CLK = 1'b0;
	logic              rst_n;
	logic              buf_we;
	logic [BUF_AW-1:0] buf_addr;
	logic [15:0]       buf_wdata;
	logic              req_valid;
	outpkt_req_t       req;
	logic              req_done;
	logic              credit_return;
	logic              out_valid;
	host_word_t        out_word;

	// copy of the buffer contents as last written
	logic [15:0]       buf_img [BUF_DEPTH];
	host_word_t        exp_words [$];
	int                exp_len [$];
	string             name_q [$];
	host_word_t        got [$];

	int   words_seen = 0;
	int   credits_sent = 0;
	int   credits_back = 0;
	int   done_cnt = 0;
	int   req_cnt = 0;
	int   pass_cnt = 0;
	int   fail_cnt = 0;
	int   misc_err = 0;
	int   hold_start;
	logic hold_credits;
	logic done_prev = 1'b0;

	outpkt_top UUT (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.buf_we        (buf_we),
		.buf_addr      (buf_addr),
		.buf_wdata     (buf_wdata),
		.req_valid     (req_valid),
		.req           (req),
		.req_done      (req_done),
		.credit_return (credit_return),
		.out_valid     (out_valid),
		.out_word      (out_word)
	);

	always #50 CLK = ~CLK;

	// expected host words of one packet from header to inverted sum
	function automatic void build_expected(input outpkt_req_t r);
		logic [15:0] w [$];
		logic [31:0] sum;
		logic [7:0]  id;
		logic [7:0]  len;
		host_word_t  hw;
		sum = '0;
		id  = '0;
		len = '0;
		case (r.pkt_type)
			PKT_DONE: begin
				id  = TYPE_ID_DONE;
				len = 8'd4;
			end
			PKT_RESULT: begin
				id  = TYPE_ID_RESULT;
				len = 8'(6 + 2 * RESULT_WORDS);
			end
			PKT_CMP_RESULT: begin
				id  = TYPE_ID_CMP_RESULT;
				len = 8'(8 + 2 * RESULT_WORDS);
			end
			default: begin
				id = '0;
			end
		endcase
		w.push_back({id, PKT_VERSION});
		w.push_back(HDR_RESERVED);
		w.push_back({8'h00, len});
		w.push_back(16'h0000);
		w.push_back(r.pkt_id);
		if (r.pkt_type == PKT_DONE) begin
			w.push_back(r.num_processed[15:0]);
			w.push_back(r.num_processed[31:16]);
		end else begin
			w.push_back(buf_img[0]);
			w.push_back(buf_img[2]);
			w.push_back(buf_img[3]);
			if (r.pkt_type == PKT_CMP_RESULT) begin
				w.push_back({8'h00, r.hash_num});
			end
			for (int i = 0; i < RESULT_WORDS; i++) begin
				w.push_back(buf_img[4 + i]);
			end
		end
		foreach (w[i]) begin
			sum = sum + {16'h0000, w[i]};
		end
		w.push_back(~sum[15:0]);
		w.push_back(~sum[31:16]);
		foreach (w[i]) begin
			hw.data = w[i];
			hw.last = (i == w.size() - 1);
			exp_words.push_back(hw);
		end
		exp_len.push_back(w.size());
	endfunction

	task automatic fill_buffer();
		logic [15:0] val;
		for (int a = 0; a < BUF_DEPTH; a++) begin
			val       = 16'($urandom);
			buf_we    = 1'b1;
			buf_addr  = BUF_AW'(a);
			buf_wdata = val;
			buf_img[a] = val;
			@(posedge CLK);
			#1;
		end
		buf_we = 1'b0;
	endtask

	// fill the buffer, raise one request and hold it until req_done
	task automatic run_request(input string name, input pkt_type_t t);
		outpkt_req_t r;
		fill_buffer();
		r.pkt_type      = t;
		r.pkt_id        = 16'($urandom);
		r.hash_num      = 8'($urandom);
		r.num_processed = $urandom;
		build_expected(r);
		name_q.push_back(name);
		req_cnt++;
		req       = r;
		req_valid = 1'b1;
		do begin
			@(posedge CLK);
			#1;
		end while (!req_done);
		req_valid = 1'b0;
	endtask

	// no credit comes back for 30 cycles while a packet is under way
	task automatic starve_credits();
		hold_credits = 1'b1;
		hold_start   = words_seen;
		fork
			run_request("starve", PKT_CMP_RESULT);
			begin
				repeat (30) @(posedge CLK);
				#1;
				if (words_seen - hold_start > OUT_CREDITS) begin
					$display("starve sent %0d words without credit returns, limit is %0d",
						words_seen - hold_start, OUT_CREDITS);
					misc_err++;
				end
				hold_credits = 1'b0;
			end
		join
	endtask

	task automatic check_packet();
		int         n;
		string      name;
		host_word_t exp_w;
		bit         bad;
		bad = 1'b0;
		if (exp_len.size() == 0) begin
			$display("packet of %0d words arrived with no request pending", got.size());
			fail_cnt++;
		end else begin
			n    = exp_len.pop_front();
			name = name_q.pop_front();
			if (got.size() != n) begin
				$display("%s came out with %0d words instead of %0d", name, got.size(), n);
				bad = 1'b1;
			end
			for (int i = 0; i < n; i++) begin
				exp_w = exp_words.pop_front();
				if (i < got.size()) begin
					if (got[i] != exp_w) begin
						$display("error %s word %0d expected %h last %0b actual %h last %0b",
							name, i, exp_w.data, exp_w.last, got[i].data, got[i].last);
						bad = 1'b1;
					end
				end
			end
			if (bad) begin
				$display("%s failed", name);
				fail_cnt++;
			end else begin
				$display("%s passed, %0d words", name, n);
				pass_cnt++;
			end
		end
		got.delete();
	endtask

	// outputs are sampled mid-cycle where they are stable
	always @(negedge CLK) begin
		if (rst_n && req_done) begin
			done_cnt++;
			if (done_prev) begin
				$display("req_done stayed high for more than one cycle");
				misc_err++;
			end
		end
		done_prev = rst_n && req_done;
		if (rst_n && out_valid) begin
			// credits returned in this cycle only count from the next one
			if (words_seen - credits_back >= OUT_CREDITS) begin
				$display("a word went out while the host held no credit");
				misc_err++;
			end
			words_seen++;
			got.push_back(out_word);
			if (out_word.last) begin
				check_packet();
			end
		end
		if (rst_n && credit_return) begin
			credits_back++;
		end
	end

	// host side returns one credit per word after a random wait
	initial begin
		int delay;
		credit_return = 1'b0;
		forever begin
			@(posedge CLK);
			if (rst_n && !hold_credits && words_seen > credits_sent) begin
				delay = $urandom_range(5, 0);
				repeat (delay) @(posedge CLK);
				if (!hold_credits) begin
					#1;
					credit_return = 1'b1;
					credits_sent++;
					@(posedge CLK);
					#1;
					credit_return = 1'b0;
				end
			end
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * 100);
		$display("watchdog ran out after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h7439));
		rst_n        = 1'b0;
		buf_we       = 1'b0;
		buf_addr     = '0;
		buf_wdata    = '0;
		req_valid    = 1'b0;
		req          = '0;
		hold_credits = 1'b0;
		repeat (16) @(posedge CLK);
		#1;
		rst_n = 1'b1;
		@(posedge CLK);
		#1;
		run_request("done", PKT_DONE);
		run_request("result", PKT_RESULT);
		run_request("cmp_result", PKT_CMP_RESULT);
		starve_credits();
		for (int i = 0; i < 20; i++) begin
			run_request($sformatf("random_%0d", i), pkt_type_t'(2'($urandom_range(2, 0))));
		end
		// checksum words of the last packet still trail req_done
		while (exp_len.size() != 0) begin
			@(posedge CLK);
			#1;
		end
		repeat (4) @(posedge CLK);
		if (done_cnt != req_cnt) begin
			$display("req_done seen %0d times for %0d requests", done_cnt, req_cnt);
			misc_err++;
		end
		$display("tests %0d passed %0d failed %0d other errors %0d",
			NUM_TESTS, pass_cnt, fail_cnt, misc_err);
		if (fail_cnt == 0 && misc_err == 0 && pass_cnt == NUM_TESTS) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
rtl/outpkt_pkg.sv
rtl/result_buffer.sv
rtl/outpkt_type_decode.sv
rtl/outpkt_formatter.sv
rtl/outpkt_checksum.sv
rtl/outpkt_top.sv
tests/outpkt_sva.sv
tests/outpkt_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= outpkt_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation output is searched for the pass line, grep sets the status
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
